// File: Makefile
# Verilator flow for the masked INTT stage testbench

TOP := ntt_masked_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -qx "Verification passed" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: src/mldsa_types_pkg.sv
// Share pairs are first-order arithmetic shares mod q; the helpers expect inputs below q
`include "ntt_params.svh"

package mldsa_types_pkg;

    typedef logic [`NTT_COEFF_W-1:0] coeff_t;

    // Value of the pair is (s0 + s1) mod q
    typedef struct packed {
        coeff_t s1;
        coeff_t s0;
    } share_pair_t;

    // Modulus one bit wider than a coefficient, for carry-safe sums
    localparam logic [`NTT_COEFF_W:0] q_wide = `NTT_MLDSA_Q;

    function automatic coeff_t add_mod(coeff_t a, coeff_t b);
        logic [`NTT_COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= q_wide) begin
            sum = sum - q_wide;
        end
        return sum[`NTT_COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod(coeff_t a, coeff_t b);
        logic [`NTT_COEFF_W:0] diff;
        diff = {1'b0, a} + q_wide - {1'b0, b};
        if (diff >= q_wide) begin
            diff = diff - q_wide;
        end
        return diff[`NTT_COEFF_W-1:0];
    endfunction

endpackage

// File: src/ntt_ctrl_pkg.sv
// Mode is quasi-static and may only change while no item is in flight
`include "ntt_params.svh"

package ntt_ctrl_pkg;

    // Butterfly operating mode
    typedef enum logic {
        intt_gs = 1'b0,
        pwm     = 1'b1
    } mode_t;

    // Per-item control carried alongside the datapath
    typedef struct packed {
        logic                   valid;
        logic [`NTT_ADDR_W-1:0] addr;
    } item_ctrl_t;

endpackage

// File: src/ntt_delay_line.sv
// DEPTH must be at least 1 and T must be a packed type; zeroize clears on the next edge
`timescale 1ns/100ps

module ntt_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  T     data_i,
    output T     data_o
);

    T pipe [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= data_i;
            // Shift towards the tail
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign data_o = pipe[DEPTH-1];

endmodule

// File: src/ntt_masked_butterfly1x2.sv
// INTT outputs are unmasked and one cycle behind the PWM share outputs
`timescale 1ns/100ps
`include "ntt_params.svh"

module ntt_masked_butterfly1x2 (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       zeroize_i,
    input  ntt_ctrl_pkg::mode_t                        mode_i,
    input  logic                                       accumulate_i,
    input  mldsa_types_pkg::share_pair_t               u00_i,
    input  mldsa_types_pkg::share_pair_t               v00_i,
    input  mldsa_types_pkg::share_pair_t               w00_i,
    input  mldsa_types_pkg::share_pair_t               u01_i,
    input  mldsa_types_pkg::share_pair_t               v01_i,
    input  mldsa_types_pkg::share_pair_t               w01_i,
    input  mldsa_types_pkg::coeff_t [`NTT_RND_N-1:0]   rnd_i,
    output mldsa_types_pkg::coeff_t                    u20_o,
    output mldsa_types_pkg::coeff_t                    u21_o,
    output mldsa_types_pkg::coeff_t                    v20_o,
    output mldsa_types_pkg::coeff_t                    v21_o,
    output mldsa_types_pkg::share_pair_t               pwm_u0_o,
    output mldsa_types_pkg::share_pair_t               pwm_u1_o
);

    // Division by two mod q
    function automatic mldsa_types_pkg::coeff_t halve_mod(mldsa_types_pkg::coeff_t x);
        logic [`NTT_COEFF_W:0] t;
        t = {1'b0, x};
        if (x[0]) begin
            t = t + mldsa_types_pkg::q_wide;
        end
        return t[`NTT_COEFF_W:1];
    endfunction

    mldsa_types_pkg::share_pair_t u10, v10, u11, v11;
    mldsa_types_pkg::share_pair_t bf_out [4];
    mldsa_types_pkg::coeff_t      halved [4];
    mldsa_types_pkg::coeff_t      res_q  [4];
    logic                         pwm_mode;

    assign pwm_mode = (mode_i == ntt_ctrl_pkg::pwm);

    ntt_masked_gs_butterfly i_bf0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .opu_i        (u00_i),
        .opv_i        (v00_i),
        .opw_i        (w00_i),
        .rnd_i        (rnd_i[1:0]),
        .u_o          (u10),
        .v_o          (v10)
    );

    // Second butterfly sees the masks rotated by one
    ntt_masked_gs_butterfly i_bf1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .opu_i        (u01_i),
        .opv_i        (v01_i),
        .opw_i        (w01_i),
        .rnd_i        ({rnd_i[2], rnd_i[1]}),
        .u_o          (u11),
        .v_o          (v11)
    );

    assign bf_out[0] = u10;
    assign bf_out[1] = v10;
    assign bf_out[2] = u11;
    assign bf_out[3] = v11;

    // Unmask and halve, zero in PWM mode
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (pwm_mode) begin
                halved[i] = '0;
            end else begin
                halved[i] = halve_mod(mldsa_types_pkg::add_mod(bf_out[i].s0, bf_out[i].s1));
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 4; i++) begin
                res_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < 4; i++) begin
                res_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                res_q[i] <= halved[i];
            end
        end
    end

    assign u20_o = res_q[0];
    assign u21_o = res_q[1];
    assign v20_o = res_q[2];
    assign v21_o = res_q[3];

    // Masked products leave without unmasking
    assign pwm_u0_o = u10;
    assign pwm_u1_o = u11;

endmodule

// File: src/ntt_masked_gs_butterfly.sv
// Fixed 3-cycle latency, no stall; all shares and random values must be below q
`timescale 1ns/100ps
`include "ntt_params.svh"

module ntt_masked_gs_butterfly (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize_i,
    input  ntt_ctrl_pkg::mode_t           mode_i,
    input  logic                          accumulate_i,
    input  mldsa_types_pkg::share_pair_t  opu_i,
    input  mldsa_types_pkg::share_pair_t  opv_i,
    input  mldsa_types_pkg::share_pair_t  opw_i,
    input  mldsa_types_pkg::coeff_t [1:0] rnd_i,
    output mldsa_types_pkg::share_pair_t  u_o,
    output mldsa_types_pkg::share_pair_t  v_o
);

    // Plain modulo reduction of a full product
    function automatic mldsa_types_pkg::coeff_t mul_mod(mldsa_types_pkg::coeff_t a,
                                                        mldsa_types_pkg::coeff_t b);
        logic [2*`NTT_COEFF_W-1:0] prod;
        logic [2*`NTT_COEFF_W-1:0] rem;
        prod = a * b;
        rem  = prod % `NTT_MLDSA_Q;
        return rem[`NTT_COEFF_W-1:0];
    endfunction

    mldsa_types_pkg::share_pair_t mul_a, mul_b, lin;
    mldsa_types_pkg::share_pair_t a_q, b_q;
    mldsa_types_pkg::share_pair_t lin_d, rnd_pair, rnd_d;
    mldsa_types_pkg::coeff_t      p00_q, p01_q, p10_q, p11_q;
    mldsa_types_pkg::share_pair_t prod_r, lin_r;
    mldsa_types_pkg::share_pair_t u_n, v_n, u_q, v_q;
    logic                         pwm_mode;

    assign pwm_mode = (mode_i == ntt_ctrl_pkg::pwm);

    // Stage 1 operand selection
    always_comb begin
        if (pwm_mode) begin
            mul_a = opu_i;
            mul_b = opv_i;
            lin   = accumulate_i ? opw_i : '0;
        end else begin
            mul_a.s0 = mldsa_types_pkg::sub_mod(opu_i.s0, opv_i.s0);
            mul_a.s1 = mldsa_types_pkg::sub_mod(opu_i.s1, opv_i.s1);
            mul_b    = opw_i;
            lin.s0   = mldsa_types_pkg::add_mod(opu_i.s0, opv_i.s0);
            lin.s1   = mldsa_types_pkg::add_mod(opu_i.s1, opv_i.s1);
        end
    end

    // Linear term and masks wait for the multiplier
    assign rnd_pair.s0 = rnd_i[0];
    assign rnd_pair.s1 = rnd_i[1];

    ntt_delay_line #(
        .T     (mldsa_types_pkg::share_pair_t),
        .DEPTH (`NTT_BF_LAT-1)
    ) i_lin_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (lin),
        .data_o    (lin_d)
    );

    ntt_delay_line #(
        .T     (mldsa_types_pkg::share_pair_t),
        .DEPTH (`NTT_BF_LAT-1)
    ) i_rnd_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (rnd_pair),
        .data_o    (rnd_d)
    );

    // Stages 1 and 2
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q   <= '0;
            b_q   <= '0;
            p00_q <= '0;
            p01_q <= '0;
            p10_q <= '0;
            p11_q <= '0;
        end else if (zeroize_i) begin
            a_q   <= '0;
            b_q   <= '0;
            p00_q <= '0;
            p01_q <= '0;
            p10_q <= '0;
            p11_q <= '0;
        end else begin
            a_q   <= mul_a;
            b_q   <= mul_b;
            // Cross products of the shares
            p00_q <= mul_mod(a_q.s0, b_q.s0);
            p01_q <= mul_mod(a_q.s0, b_q.s1);
            p10_q <= mul_mod(a_q.s1, b_q.s0);
            p11_q <= mul_mod(a_q.s1, b_q.s1);
        end
    end

    // Stage 3 recombination with fresh masks
    always_comb begin
        prod_r.s0 = mldsa_types_pkg::add_mod(mldsa_types_pkg::add_mod(p00_q, p01_q), rnd_d.s0);
        prod_r.s1 = mldsa_types_pkg::sub_mod(mldsa_types_pkg::add_mod(p10_q, p11_q), rnd_d.s0);
        lin_r.s0  = mldsa_types_pkg::add_mod(lin_d.s0, rnd_d.s1);
        lin_r.s1  = mldsa_types_pkg::sub_mod(lin_d.s1, rnd_d.s1);
        if (pwm_mode) begin
            u_n.s0 = mldsa_types_pkg::add_mod(prod_r.s0, lin_r.s0);
            u_n.s1 = mldsa_types_pkg::add_mod(prod_r.s1, lin_r.s1);
            v_n    = '0;
        end else begin
            u_n = lin_r;
            v_n = prod_r;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_q <= '0;
            v_q <= '0;
        end else if (zeroize_i) begin
            u_q <= '0;
            v_q <= '0;
        end else begin
            u_q <= u_n;
            v_q <= v_n;
        end
    end

    assign u_o = u_q;
    assign v_o = v_q;

endmodule

// File: src/ntt_masked_intt_stage.sv
// No back-pressure so every valid_i item is emitted; mode and accumulate change only when idle
`timescale 1ns/100ps
`include "ntt_params.svh"

module ntt_masked_intt_stage (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       zeroize_i,
    input  logic                                       valid_i,
    input  logic [`NTT_ADDR_W-1:0]                     addr_i,
    input  ntt_ctrl_pkg::mode_t                        mode_i,
    input  logic                                       accumulate_i,
    input  mldsa_types_pkg::share_pair_t               u00_i,
    input  mldsa_types_pkg::share_pair_t               v00_i,
    input  mldsa_types_pkg::share_pair_t               w00_i,
    input  mldsa_types_pkg::share_pair_t               u01_i,
    input  mldsa_types_pkg::share_pair_t               v01_i,
    input  mldsa_types_pkg::share_pair_t               w01_i,
    input  mldsa_types_pkg::coeff_t [`NTT_RND_N-1:0]   rnd_i,
    output logic                                       intt_valid_o,
    output logic [`NTT_ADDR_W-1:0]                     intt_addr_o,
    output mldsa_types_pkg::coeff_t                    u20_o,
    output mldsa_types_pkg::coeff_t                    u21_o,
    output mldsa_types_pkg::coeff_t                    v20_o,
    output mldsa_types_pkg::coeff_t                    v21_o,
    output logic                                       pwm_valid_o,
    output logic [`NTT_ADDR_W-1:0]                     pwm_addr_o,
    output mldsa_types_pkg::share_pair_t               pwm_u0_o,
    output mldsa_types_pkg::share_pair_t               pwm_u1_o
);

    ntt_ctrl_pkg::item_ctrl_t in_ctrl, pwm_ctrl, intt_ctrl;

    assign in_ctrl.valid = valid_i;
    assign in_ctrl.addr  = addr_i;

    ntt_masked_butterfly1x2 i_bf1x2 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u00_i        (u00_i),
        .v00_i        (v00_i),
        .w00_i        (w00_i),
        .u01_i        (u01_i),
        .v01_i        (v01_i),
        .w01_i        (w01_i),
        .rnd_i        (rnd_i),
        .u20_o        (u20_o),
        .u21_o        (u21_o),
        .v20_o        (v20_o),
        .v21_o        (v21_o),
        .pwm_u0_o     (pwm_u0_o),
        .pwm_u1_o     (pwm_u1_o)
    );

    // PWM shares leave straight from the butterflies
    ntt_delay_line #(
        .T     (ntt_ctrl_pkg::item_ctrl_t),
        .DEPTH (`NTT_BF_LAT)
    ) i_pwm_ctrl_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (in_ctrl),
        .data_o    (pwm_ctrl)
    );

    // INTT results pass one more register
    ntt_delay_line #(
        .T     (ntt_ctrl_pkg::item_ctrl_t),
        .DEPTH (`NTT_BF_LAT+1)
    ) i_intt_ctrl_dly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .data_i    (in_ctrl),
        .data_o    (intt_ctrl)
    );

    // Strobes follow the mode and drop at once on zeroize
    assign intt_valid_o = intt_ctrl.valid & (mode_i == ntt_ctrl_pkg::intt_gs) & ~zeroize_i;
    assign pwm_valid_o  = pwm_ctrl.valid & (mode_i == ntt_ctrl_pkg::pwm) & ~zeroize_i;
    assign intt_addr_o  = intt_ctrl.addr;
    assign pwm_addr_o   = pwm_ctrl.addr;

endmodule

// File: src/ntt_params.svh
// Widths and latencies assume ML-DSA q = 8380417 and shares kept fully reduced below q
`ifndef NTT_PARAMS_SVH
`define NTT_PARAMS_SVH

// ML-DSA prime modulus
`define NTT_MLDSA_Q 8380417

// Width of one coefficient or one share
`define NTT_COEFF_W 23

// Coefficient address carried next to each item
`define NTT_ADDR_W 8

// Register stages inside one masked butterfly
`define NTT_BF_LAT 3

// Random values consumed per input item
`define NTT_RND_N 3

`endif

// File: tb.f
+incdir+src
src/mldsa_types_pkg.sv
src/ntt_ctrl_pkg.sv
src/ntt_delay_line.sv
src/ntt_masked_gs_butterfly.sv
src/ntt_masked_butterfly1x2.sv
src/ntt_masked_intt_stage.sv
tb/ntt_tb_clk_gen.sv
tb/ntt_masked_assert.sv
tb/ntt_masked_tb.sv

// File: tb/ntt_masked_assert.sv
// Checks output strobes only; assumes mode_i is stable while items are in flight
`timescale 1ns/100ps

module ntt_masked_assert (
    input logic                clk,
    input logic                reset_n,
    input logic                zeroize_i,
    input logic                valid_i,
    input ntt_ctrl_pkg::mode_t mode_i,
    input logic                intt_valid_i,
    input logic                pwm_valid_i
);

    int fail_count = 0;

    // One kind of result per cycle
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(intt_valid_i && pwm_valid_i)
    ) else begin
        fail_count++;
        $error("intt_valid_o and pwm_valid_o are high in the same cycle");
    end

    // Every INTT item leaves after the butterfly plus one output register
    intt_latency: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize_i)
        (valid_i && mode_i == ntt_ctrl_pkg::intt_gs) |-> ##4 intt_valid_i
    ) else begin
        fail_count++;
        $error("intt_valid_o missing four cycles after an INTT input");
    end

    strobes_low_on_zeroize: assert property (
        @(posedge clk) disable iff (!reset_n)
        zeroize_i |-> (!intt_valid_i && !pwm_valid_i)
    ) else begin
        fail_count++;
        $error("output strobe high while zeroize_i is high");
    end

endmodule

// File: tb/ntt_masked_tb.sv
// Directed tests; mode and accumulate change only after the pipeline has drained
`timescale 1ns/100ps
`include "ntt_params.svh"

module ntt_masked_tb;

    localparam int clk_period     = 20;
    localparam int reset_cycles   = 16;
    localparam int max_items      = 8;
    localparam int strobe_timeout = 12;
    localparam int idle_cycles    = 8;
    localparam int batches        = 5;
    // Longest possible run of all tests plus a margin
    localparam int run_cycles = 2 * reset_cycles
                              + batches * (max_items + strobe_timeout + idle_cycles) + 100;
    localparam logic [31:0] q    = `NTT_MLDSA_Q;
    localparam logic [31:0] inv2 = (`NTT_MLDSA_Q + 1) / 2;

    typedef struct packed {
        logic [`NTT_ADDR_W-1:0]                   addr;
        mldsa_types_pkg::share_pair_t             u00, v00, w00, u01, v01, w01;
        mldsa_types_pkg::coeff_t [`NTT_RND_N-1:0] rnd;
    } item_t;

    typedef struct packed {
        logic [`NTT_ADDR_W-1:0]  addr;
        logic [31:0]             cap;
        mldsa_types_pkg::coeff_t r0, r1, r2, r3;
    } expect_t;

    logic                                     clk;
    logic                                     reset_n;
    logic                                     zeroize;
    logic                                     valid;
    logic [`NTT_ADDR_W-1:0]                   addr;
    ntt_ctrl_pkg::mode_t                      mode;
    logic                                     accumulate;
    mldsa_types_pkg::share_pair_t             u00, v00, w00, u01, v01, w01;
    mldsa_types_pkg::coeff_t [`NTT_RND_N-1:0] rnd;
    logic                                     intt_valid, pwm_valid;
    logic [`NTT_ADDR_W-1:0]                   intt_addr, pwm_addr;
    mldsa_types_pkg::coeff_t                  u20, u21, v20, v21;
    mldsa_types_pkg::share_pair_t             pwm_u0, pwm_u1;

    integer                       seed;
    int                           mismatch_count;
    int                           fail_count;
    logic [31:0]                  cycle_cnt = '0;
    item_t                        items [max_items];
    expect_t                      expect_q [$];
    mldsa_types_pkg::share_pair_t obs_u0_q [$];
    mldsa_types_pkg::share_pair_t obs_u1_q [$];

    ntt_tb_clk_gen #(.PERIOD_NS(clk_period)) i_clk_gen (.clk_o(clk));

    ntt_masked_intt_stage i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .valid_i      (valid),
        .addr_i       (addr),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .u00_i        (u00),
        .v00_i        (v00),
        .w00_i        (w00),
        .u01_i        (u01),
        .v01_i        (v01),
        .w01_i        (w01),
        .rnd_i        (rnd),
        .intt_valid_o (intt_valid),
        .intt_addr_o  (intt_addr),
        .u20_o        (u20),
        .u21_o        (u21),
        .v20_o        (v20),
        .v21_o        (v21),
        .pwm_valid_o  (pwm_valid),
        .pwm_addr_o   (pwm_addr),
        .pwm_u0_o     (pwm_u0),
        .pwm_u1_o     (pwm_u1)
    );

    bind ntt_masked_intt_stage ntt_masked_assert i_assert (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .valid_i      (valid_i),
        .mode_i       (mode_i),
        .intt_valid_i (intt_valid_o),
        .pwm_valid_i  (pwm_valid_o)
    );

    // Edge k leaves cycle_cnt at k
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic mldsa_types_pkg::coeff_t rand_coeff();
        logic [31:0] r;
        logic [31:0] m;
        r = $random(seed);
        m = r % q;
        return m[`NTT_COEFF_W-1:0];
    endfunction

    function automatic mldsa_types_pkg::share_pair_t rand_pair();
        mldsa_types_pkg::share_pair_t p;
        p.s0 = rand_coeff();
        p.s1 = rand_coeff();
        return p;
    endfunction

    function automatic logic [31:0] combine(mldsa_types_pkg::share_pair_t p);
        return ({9'b0, p.s0} + {9'b0, p.s1}) % q;
    endfunction

    function automatic logic [31:0] mul_q(logic [31:0] a, logic [31:0] b);
        logic [63:0] p;
        p = {32'b0, a} * {32'b0, b};
        p = p % {32'b0, q};
        return p[31:0];
    endfunction

    // Halving mod q is a multiplication by the inverse of 2
    function automatic logic [31:0] half_q(logic [31:0] x);
        return mul_q(x, inv2);
    endfunction

    function automatic expect_t reference(item_t it, ntt_ctrl_pkg::mode_t m, logic acc,
                                          logic [31:0] cap);
        expect_t     e;
        logic [31:0] u0, v0, w0, u1, v1, w1;
        logic [31:0] x0, x1, x2, x3;
        u0 = combine(it.u00);
        v0 = combine(it.v00);
        w0 = combine(it.w00);
        u1 = combine(it.u01);
        v1 = combine(it.v01);
        w1 = combine(it.w01);
        if (m == ntt_ctrl_pkg::intt_gs) begin
            x0 = half_q((u0 + v0) % q);
            x1 = half_q(mul_q((u0 + q - v0) % q, w0));
            x2 = half_q((u1 + v1) % q);
            x3 = half_q(mul_q((u1 + q - v1) % q, w1));
        end else begin
            x0 = (mul_q(u0, v0) + (acc ? w0 : 32'd0)) % q;
            x1 = (mul_q(u1, v1) + (acc ? w1 : 32'd0)) % q;
            x2 = 32'd0;
            x3 = 32'd0;
        end
        e.addr = it.addr;
        e.cap  = cap;
        e.r0   = x0[`NTT_COEFF_W-1:0];
        e.r1   = x1[`NTT_COEFF_W-1:0];
        e.r2   = x2[`NTT_COEFF_W-1:0];
        e.r3   = x3[`NTT_COEFF_W-1:0];
        return e;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        mismatch_count++;
        $display("MISMATCH at %0d ns: %s got 0x%0h expected 0x%0h", $time, what, got, want);
    endtask

    task automatic clear_inputs();
        valid = 1'b0;
        addr  = '0;
        u00   = '0;
        v00   = '0;
        w00   = '0;
        u01   = '0;
        v01   = '0;
        w01   = '0;
        rnd   = '0;
    endtask

    task automatic apply_item(input item_t it);
        valid = 1'b1;
        addr  = it.addr;
        u00   = it.u00;
        v00   = it.v00;
        w00   = it.w00;
        u01   = it.u01;
        v01   = it.v01;
        w01   = it.w01;
        rnd   = it.rnd;
    endtask

    task automatic make_items(input int n, input logic [`NTT_ADDR_W-1:0] base);
        for (int i = 0; i < n; i++) begin
            items[i].addr = base + `NTT_ADDR_W'(i);
            items[i].u00  = rand_pair();
            items[i].v00  = rand_pair();
            items[i].w00  = rand_pair();
            items[i].u01  = rand_pair();
            items[i].v01  = rand_pair();
            items[i].w01  = rand_pair();
            for (int k = 0; k < `NTT_RND_N; k++) begin
                items[i].rnd[k] = rand_coeff();
            end
        end
    endtask

    task automatic set_mode(input ntt_ctrl_pkg::mode_t m, input logic acc);
        @(negedge clk);
        mode       = m;
        accumulate = acc;
    endtask

    task automatic check_all_zero(input string when);
        if ({intt_valid, pwm_valid} !== 2'b00) begin
            report_mismatch({when, ": strobes"}, {30'b0, intt_valid, pwm_valid}, 32'd0);
        end
        if ({u20, u21, v20, v21, intt_addr} !== '0) begin
            report_mismatch({when, ": INTT outputs nonzero"}, 32'd1, 32'd0);
        end
        if ({pwm_u0, pwm_u1, pwm_addr} !== '0) begin
            report_mismatch({when, ": PWM outputs nonzero"}, 32'd1, 32'd0);
        end
    endtask

    task automatic check_item(input expect_t e);
        logic [31:0] lat;
        lat = cycle_cnt + 1 - e.cap;
        if (mode == ntt_ctrl_pkg::pwm) begin
            obs_u0_q.push_back(pwm_u0);
            obs_u1_q.push_back(pwm_u1);
            if (lat != `NTT_BF_LAT) report_mismatch("PWM latency", lat, `NTT_BF_LAT);
            if (pwm_addr !== e.addr) report_mismatch("pwm_addr_o", pwm_addr, e.addr);
            if (combine(pwm_u0) !== e.r0) report_mismatch("pwm_u0_o value", combine(pwm_u0), e.r0);
            if (combine(pwm_u1) !== e.r1) report_mismatch("pwm_u1_o value", combine(pwm_u1), e.r1);
            if ({u20, u21, v20, v21} !== '0) report_mismatch("INTT data in PWM mode", 32'd1, 32'd0);
        end else begin
            if (lat != `NTT_BF_LAT + 1) report_mismatch("INTT latency", lat, `NTT_BF_LAT + 1);
            if (intt_addr !== e.addr) report_mismatch("intt_addr_o", intt_addr, e.addr);
            if (u20 !== e.r0) report_mismatch("u20_o", u20, e.r0);
            if (u21 !== e.r1) report_mismatch("u21_o", u21, e.r1);
            if (v20 !== e.r2) report_mismatch("v20_o", v20, e.r2);
            if (v21 !== e.r3) report_mismatch("v21_o", v21, e.r3);
        end
    endtask

    task automatic drive_batch(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            apply_item(items[i]);
            expect_q.push_back(reference(items[i], mode, accumulate, cycle_cnt + 1));
        end
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic collect_batch(input int n);
        int      waited;
        logic    seen;
        expect_t e;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < strobe_timeout) begin
                @(negedge clk);
                seen = (mode == ntt_ctrl_pkg::pwm) ? pwm_valid : intt_valid;
                waited++;
            end
            if (!seen) begin
                fail_count++;
                $display("No output strobe for item %0d within %0d cycles at %0d ns",
                         k, strobe_timeout, $time);
                return;
            end
            if (expect_q.size() == 0) begin
                fail_count++;
                $display("Output strobe at %0d ns with no item outstanding", $time);
            end else begin
                e = expect_q.pop_front();
                check_item(e);
            end
        end
    endtask

    task automatic run_batch(input int n);
        fork
            drive_batch(n);
            collect_batch(n);
        join
        expect_q.delete();
        // Every item has left, so any further strobe is spurious
        repeat (idle_cycles) begin
            @(negedge clk);
            if (intt_valid || pwm_valid) begin
                fail_count++;
                $display("Unexpected output strobe after the batch at %0d ns", $time);
            end
        end
    endtask

    task automatic single_intt_item();
        set_mode(ntt_ctrl_pkg::intt_gs, 1'b0);
        make_items(1, 8'h10);
        run_batch(1);
    endtask

    task automatic back_to_back_intt();
        set_mode(ntt_ctrl_pkg::intt_gs, 1'b0);
        make_items(6, 8'h20);
        run_batch(6);
    endtask

    task automatic pwm_product();
        set_mode(ntt_ctrl_pkg::pwm, 1'b0);
        make_items(2, 8'h40);
        run_batch(2);
    endtask

    task automatic pwm_accumulate();
        set_mode(ntt_ctrl_pkg::pwm, 1'b1);
        make_items(4, 8'h60);
        run_batch(4);
    endtask

    // Same operands twice, masks shifted for the second pass
    task automatic share_refresh();
        logic [31:0] t;
        set_mode(ntt_ctrl_pkg::pwm, 1'b1);
        make_items(1, 8'h80);
        items[1] = items[0];
        for (int k = 0; k < `NTT_RND_N; k++) begin
            t = ({9'b0, items[0].rnd[k]} + k + 1) % q;
            items[1].rnd[k] = t[`NTT_COEFF_W-1:0];
        end
        obs_u0_q.delete();
        obs_u1_q.delete();
        run_batch(2);
        if (obs_u0_q.size() != 2) begin
            fail_count++;
            $display("Masking test saw %0d of 2 PWM results", obs_u0_q.size());
        end else begin
            if (obs_u0_q[0] == obs_u0_q[1]) begin
                fail_count++;
                $display("pwm_u0_o shares did not change with fresh random values");
            end
            if (obs_u1_q[0] == obs_u1_q[1]) begin
                fail_count++;
                $display("pwm_u1_o shares did not change with fresh random values");
            end
            if (combine(obs_u0_q[0]) != combine(obs_u0_q[1])) begin
                report_mismatch("remasked pwm_u0_o", combine(obs_u0_q[1]), combine(obs_u0_q[0]));
            end
            if (combine(obs_u1_q[0]) != combine(obs_u1_q[1])) begin
                report_mismatch("remasked pwm_u1_o", combine(obs_u1_q[1]), combine(obs_u1_q[0]));
            end
        end
    endtask

    task automatic zeroize_and_reset();
        set_mode(ntt_ctrl_pkg::intt_gs, 1'b0);
        make_items(3, 8'ha0);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            apply_item(items[i]);
        end
        // Flush while three items are in flight
        @(negedge clk);
        clear_inputs();
        zeroize = 1'b1;
        @(negedge clk);
        check_all_zero("during zeroize");
        @(negedge clk);
        zeroize = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_all_zero("after zeroize");
        end
        make_items(3, 8'hc0);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            apply_item(items[i]);
        end
        @(negedge clk);
        clear_inputs();
        reset_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        check_all_zero("during reset");
        reset_n = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_all_zero("after reset");
        end
    endtask

    initial begin
        seed           = 32'hb9ec;
        mismatch_count = 0;
        fail_count     = 0;
        reset_n        = 1'b0;
        zeroize        = 1'b0;
        mode           = ntt_ctrl_pkg::intt_gs;
        accumulate     = 1'b0;
        clear_inputs();
        repeat (reset_cycles) @(negedge clk);
        check_all_zero("initial reset");
        reset_n = 1'b1;
        repeat (2) @(negedge clk);
        single_intt_item();
        back_to_back_intt();
        pwm_product();
        pwm_accumulate();
        share_refresh();
        zeroize_and_reset();
        $display("Done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, fail_count, i_dut.i_assert.fail_count);
        if (mismatch_count + fail_count + i_dut.i_assert.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(run_cycles * clk_period);
        $display("Watchdog expired after %0d cycles before the tests finished", run_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: tb/ntt_tb_clk_gen.sv
// Free-running clock that starts low; PERIOD_NS should be an even number of ns
`timescale 1ns/100ps

module ntt_tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule
